/* logic/sorter_pkg.sv */
package sorter_pkg;

  // --------------------
  // field widths
  // --------------------

  // pattern id, upper six bits sort, bit 0 is bend direction
  localparam int PAT_W    = 7;
  // half-strip key inside one candidate slice
  localparam int KEY_W    = 5;
  // ccLUT position offset
  localparam int OFFS_W   = 4;
  // ccLUT fit quality
  localparam int QLT_W    = 6;
  localparam int BEND_W   = 4;
  // comparator code carried with the pattern
  localparam int CARRY_W  = 12;
  localparam int SORT_W   = 6;
  localparam int N_CAND   = 7;
  // extended key is {candidate index, key}
  localparam int KEYX_W   = 8;
  localparam int IDX_W    = KEYX_W - KEY_W;
  // sub-key adds two quarter-strip bits below the extended key
  localparam int SUBKEY_W = 10;

  // apb bus
  localparam int APB_AW   = 8;
  localparam int APB_DW   = 32;

  // --------------------
  // candidate and result
  // --------------------

  // one half-strip pattern candidate, 39 bits
  typedef struct packed {
    logic [PAT_W-1:0]   pat;
    logic [KEY_W-1:0]   key;
    logic [OFFS_W-1:0]  offs;
    logic [QLT_W-1:0]   qlt;
    logic [BEND_W-1:0]  bend;
    logic [CARRY_W-1:0] carry;
    logic               bsy;
  } cand_t;

  // prepared group with per-candidate sort keys, 315 bits
  typedef struct packed {
    cand_t [N_CAND-1:0]             cand;
    logic  [N_CAND-1:0][SORT_W-1:0] sort_key;
  } group_t;

  // sorted best candidate, 48 bits
  typedef struct packed {
    logic [PAT_W-1:0]    pat;
    logic [KEYX_W-1:0]   best_key;
    logic [BEND_W-1:0]   bend;
    logic [CARRY_W-1:0]  carry;
    logic [SUBKEY_W-1:0] subkey;
    logic [QLT_W-1:0]    qlt;
    logic                bsy;
  } best_t;

  // --------------------
  // register map
  // --------------------

  typedef enum logic [APB_AW-1:0] {
    CTRL     = 8'h00,
    BSY_MASK = 8'h04,
    COUNT    = 8'h08,
    LAST     = 8'h0C
  } reg_addr_e;

endpackage

/* logic/candidate_sampler.sv */
`timescale 1ns/1ps

module candidate_sampler import sorter_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  cand_t [N_CAND-1:0]  in_group,
  input  logic                in_valid,
  output logic                in_ready,
  input  logic                sort_on_qlt,
  input  logic [N_CAND-1:0]   bsy_mask,
  output group_t              samp_group,
  output logic                samp_valid,
  input  logic                samp_ready
);

  // prepared group, before the output register
  group_t prep;
  logic   in_fire;
  // low until the first cycle out of reset
  logic   run_q;

  // --------------------
  // group preparation
  // --------------------

  always_comb
  begin
    for (int i = 0; i < N_CAND; i++)
    begin
      prep.cand[i] = in_group[i];
      // busy from the chamber or forced by the mask register
      prep.cand[i].bsy = in_group[i].bsy | bsy_mask[i];
      // quality after the fit, or the sortable pattern bits
      if (sort_on_qlt)
        prep.sort_key[i] = in_group[i].qlt;
      else
        prep.sort_key[i] = in_group[i].pat[PAT_W-1:1];
    end
  end

  // --------------------
  // output stage
  // --------------------

  // accept when empty or draining this cycle, so one group per clock
  assign in_ready = run_q && (!samp_valid || samp_ready);
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      run_q      <= 1'b0;
      samp_valid <= 1'b0;
    end
    else
    begin
      run_q <= 1'b1;
      if (in_fire)
        samp_valid <= 1'b1;
      else if (samp_ready)
        samp_valid <= 1'b0;
    end
  end

  // payload only moves on an accepted group
  always_ff @(posedge clk)
  begin
    if (in_fire)
      samp_group <= prep;
  end

endmodule

/* logic/candidate_fifo.sv */
`timescale 1ns/1ps

module candidate_fifo import sorter_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic   clk,
  input  logic   rst_n,
  input  group_t samp_group,
  input  logic   samp_valid,
  output logic   samp_ready,
  output group_t fifo_group,
  output logic   fifo_valid,
  input  logic   fifo_ready
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // group storage
  group_t mem [FIFO_DEPTH];

  // pointers carry one wrap bit above the index
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;
  logic           full;
  logic           empty;
  logic           wr_en;
  logic           rd_en;

  // --------------------
  // flags
  // --------------------

  assign empty = (wr_ptr == rd_ptr);
  // same slot but different lap
  assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

  assign samp_ready = !full;
  assign fifo_valid = !empty;
  assign wr_en      = samp_valid && !full;
  assign rd_en      = fifo_valid && fifo_ready;

  // head of queue, visible the cycle after its write
  assign fifo_group = mem[rd_ptr[PTR_W-1:0]];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr[PTR_W-1:0]] <= samp_group;
  end

endmodule

/* logic/best_1of7_sorter.sv */
`timescale 1ns/1ps

module best_1of7_sorter import sorter_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  group_t fifo_group,
  input  logic   fifo_valid,
  output logic   fifo_ready,
  output best_t  out_best,
  output logic   out_valid,
  input  logic   out_ready,
  output logic   result_fire
);

  // candidates that pass the priority rule on their own
  logic [N_CAND-1:0]   wins;
  logic                found;
  logic [IDX_W-1:0]    sel_idx;
  cand_t               win_c;
  logic [KEYX_W-1:0]   key_x;
  logic [1:0]          sub_lo;
  best_t               nxt;
  logic                pop;

  // --------------------
  // selection
  // --------------------

  // strictly above every lower index, busy ones still compared
  always_comb
  begin
    for (int i = 0; i < N_CAND; i++)
    begin
      wins[i] = !fifo_group.cand[i].bsy;
      for (int j = 0; j < i; j++)
      begin
        if (fifo_group.sort_key[i] <= fifo_group.sort_key[j])
          wins[i] = 1'b0;
      end
    end
  end

  // highest index takes priority, candidate 0 only needs to be free
  always_comb
  begin
    found   = 1'b0;
    sel_idx = '0;
    for (int i = N_CAND - 1; i >= 0; i--)
    begin
      if (!found && wins[i])
      begin
        found   = 1'b1;
        sel_idx = IDX_W'(i);
      end
    end
  end

  assign win_c = fifo_group.cand[sel_idx];

  // --------------------
  // key arithmetic
  // --------------------

  // coarse offset correction, wraps at 256
  assign key_x = {sel_idx, win_c.key}
               + KEYX_W'(win_c.offs[3:2])
               + KEYX_W'(win_c.offs[1] & win_c.offs[0])
               - KEYX_W'(2);

  // quarter-strip bits, 2-bit wrap
  assign sub_lo = win_c.offs[1:0] + 2'd1;

  always_comb
  begin
    nxt     = '0;
    // nothing free in the group
    nxt.bsy = 1'b1;
    if (found)
    begin
      nxt.pat      = win_c.pat;
      nxt.best_key = key_x;
      nxt.bend     = win_c.bend;
      nxt.carry    = win_c.carry;
      nxt.subkey   = {key_x, sub_lo};
      nxt.qlt      = win_c.qlt;
      nxt.bsy      = 1'b0;
    end
  end

  // --------------------
  // output register
  // --------------------

  // take a new group when empty or the current result leaves
  assign fifo_ready  = !out_valid || out_ready;
  assign pop         = fifo_valid && fifo_ready;
  assign result_fire = out_valid && out_ready;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      out_valid <= 1'b0;
    else if (pop)
      out_valid <= 1'b1;
    else if (out_ready)
      out_valid <= 1'b0;
  end

  // held while out_ready is low
  always_ff @(posedge clk)
  begin
    if (pop)
      out_best <= nxt;
  end

endmodule

/* logic/sorter_apb_regs.sv */
`timescale 1ns/1ps

module sorter_apb_regs import sorter_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [APB_AW-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_DW-1:0] pwdata,
  output logic [APB_DW-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              sort_on_qlt,
  output logic [N_CAND-1:0] bsy_mask,
  input  logic              result_fire,
  input  best_t             out_best
);

  localparam int COUNT_W = 16;
  // {bsy, qlt, subkey}
  localparam int LAST_W  = SUBKEY_W + QLT_W + 1;

  reg_addr_e          addr;
  logic               access;
  logic               bad_addr;
  logic               wr_en;
  logic [COUNT_W-1:0] count_q;
  logic [LAST_W-1:0]  last_q;

  assign addr   = reg_addr_e'(paddr);
  assign access = psel && penable;
  // no wait states
  assign pready = 1'b1;

  // --------------------
  // decode
  // --------------------

  always_comb
  begin
    case (addr)
      CTRL, BSY_MASK: bad_addr = 1'b0;
      // status registers are read only
      COUNT, LAST:    bad_addr = pwrite;
      default:        bad_addr = 1'b1;
    endcase
  end

  assign pslverr = access && bad_addr;
  assign wr_en   = access && pwrite && !bad_addr;

  // unused bits read back as zero
  always_comb
  begin
    prdata = '0;
    case (addr)
      CTRL:     prdata[0] = sort_on_qlt;
      BSY_MASK: prdata[N_CAND-1:0] = bsy_mask;
      COUNT:    prdata[COUNT_W-1:0] = count_q;
      LAST:     prdata[LAST_W-1:0] = last_q;
      default:  prdata = '0;
    endcase
  end

  // --------------------
  // registers
  // --------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sort_on_qlt <= 1'b0;
      bsy_mask    <= '0;
      count_q     <= '0;
      last_q      <= '0;
    end
    else
    begin
      if (wr_en && addr == CTRL)
        sort_on_qlt <= pwdata[0];
      if (wr_en && addr == BSY_MASK)
        bsy_mask <= pwdata[N_CAND-1:0];
      // counter sticks at all ones
      if (result_fire && count_q != {COUNT_W{1'b1}})
        count_q <= count_q + 1'b1;
      if (result_fire)
        last_q <= {out_best.bsy, out_best.qlt, out_best.subkey};
    end
  end

endmodule

/* logic/clct_sorter_top.sv */
`timescale 1ns/1ps

module clct_sorter_top import sorter_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  // candidate stream in
  input  cand_t [N_CAND-1:0] in_group,
  input  logic               in_valid,
  output logic               in_ready,
  // best candidate stream out
  output best_t              out_best,
  output logic               out_valid,
  input  logic               out_ready,
  // apb slave
  input  logic [APB_AW-1:0]  paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [APB_DW-1:0]  pwdata,
  output logic [APB_DW-1:0]  prdata,
  output logic               pready,
  output logic               pslverr
);

  // sampler to fifo
  group_t            samp_group;
  logic              samp_valid;
  logic              samp_ready;
  // fifo to sorter
  group_t            fifo_group;
  logic              fifo_valid;
  logic              fifo_ready;
  // config and status
  logic              sort_on_qlt;
  logic [N_CAND-1:0] bsy_mask;
  logic              result_fire;

  candidate_sampler sampler_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_group    (in_group),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .sort_on_qlt (sort_on_qlt),
    .bsy_mask    (bsy_mask),
    .samp_group  (samp_group),
    .samp_valid  (samp_valid),
    .samp_ready  (samp_ready)
  );

  candidate_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .samp_group (samp_group),
    .samp_valid (samp_valid),
    .samp_ready (samp_ready),
    .fifo_group (fifo_group),
    .fifo_valid (fifo_valid),
    .fifo_ready (fifo_ready)
  );

  best_1of7_sorter sorter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .fifo_group  (fifo_group),
    .fifo_valid  (fifo_valid),
    .fifo_ready  (fifo_ready),
    .out_best    (out_best),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .result_fire (result_fire)
  );

  sorter_apb_regs regs_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .sort_on_qlt (sort_on_qlt),
    .bsy_mask    (bsy_mask),
    .result_fire (result_fire),
    .out_best    (out_best)
  );

endmodule

/* tb/tb_clct_sorter.sv */
`timescale 1ns/1ps

module tb_clct_sorter
  import sorter_pkg::*;
();

  localparam int TIMEOUT = 200;

  typedef cand_t [N_CAND-1:0] grp_t;
  typedef logic [N_CAND-1:0][SORT_W-1:0] sv_t;

  // one row of the stimulus table
  typedef struct packed {
    grp_t              grp;
    logic              sort_on_qlt;
    logic [N_CAND-1:0] bsy_mask;
    logic [7:0]        rdy_pat;
    logic              lat_chk;
  } stim_t;

  logic              clk = 1'b0;
  logic              rst_n;
  grp_t              in_group;
  logic              in_valid;
  logic              in_ready;
  best_t             out_best;
  logic              out_valid;
  logic              out_ready;
  logic [APB_AW-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;

  int         seed = 32'h195bffe3;
  int         errors = 0;
  int         accepted = 0;
  int         cyc = 0;
  logic [7:0] cur_pat = 8'hFF;
  logic       saw_in_stall = 1'b0;
  best_t      last_exp = '0;
  stim_t      table_q[$];
  best_t      exp_q[$];
  // transfer cycle of each group or -1 when latency is not checked
  int         lat_q[$];

  clct_sorter_top #(
    .FIFO_DEPTH (4)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_group  (in_group),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_best  (out_best),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1;

  // --------------------
  // reference model
  // --------------------

  function automatic best_t ref_best(input grp_t g, input logic by_qlt,
                                     input logic [N_CAND-1:0] mask);
    logic [SORT_W-1:0] sk [N_CAND];
    logic              higher;
    int                pick;
    int                kx;
    int                lo;
    best_t             r;
    pick = -1;
    for (int i = 0; i < N_CAND; i++)
      sk[i] = by_qlt ? g[i].qlt : g[i].pat[PAT_W-1:1];
    // top index first and it must beat all lower ones including busy ones
    for (int i = N_CAND - 1; i >= 0 && pick < 0; i--)
    begin
      higher = 1'b1;
      for (int j = 0; j < i; j++)
        if (sk[j] >= sk[i])
          higher = 1'b0;
      if (!(g[i].bsy | mask[i]) && higher)
        pick = i;
    end
    r = '0;
    if (pick < 0)
    begin
      r.bsy = 1'b1;
      return r;
    end
    kx = pick * 32 + int'(g[pick].key) + int'(g[pick].offs[3:2])
       + int'(g[pick].offs[1] & g[pick].offs[0]) - 2;
    lo = int'(g[pick].offs[1:0]) + 1;
    r.pat      = g[pick].pat;
    r.best_key = KEYX_W'(kx);
    r.bend     = g[pick].bend;
    r.carry    = g[pick].carry;
    r.subkey   = {r.best_key, 2'(lo)};
    r.qlt      = g[pick].qlt;
    return r;
  endfunction

  // --------------------
  // stimulus table
  // --------------------

  // candidate i gets pattern sort value ps[i] and quality qs[i]
  function automatic grp_t graded(input sv_t ps, input sv_t qs, input logic [N_CAND-1:0] busy);
    grp_t g;
    for (int i = 0; i < N_CAND; i++)
    begin
      g[i].pat   = {ps[i], 1'b1};
      g[i].key   = KEY_W'(3 * i + 1);
      g[i].offs  = OFFS_W'(i);
      g[i].qlt   = qs[i];
      g[i].bend  = BEND_W'(i);
      g[i].carry = CARRY_W'(100 * i + 7);
      g[i].bsy   = busy[i];
    end
    return g;
  endfunction

  function automatic cand_t rand_cand();
    logic [31:0] a;
    logic [31:0] b;
    cand_t       c;
    a = $random(seed);
    b = $random(seed);
    c = {a, b[6:0]};
    // busy about one time in eight
    c.bsy = (b[31:29] == 3'b000);
    return c;
  endfunction

  task automatic add_row(input grp_t g, input logic q, input logic [N_CAND-1:0] m,
                         input logic [7:0] rp, input logic lc);
    stim_t s;
    s.grp         = g;
    s.sort_on_qlt = q;
    s.bsy_mask    = m;
    s.rdy_pat     = rp;
    s.lat_chk     = lc;
    table_q.push_back(s);
  endtask

  task automatic build_table();
    grp_t        g;
    sv_t         ramp;
    logic [31:0] a;
    logic [31:0] b;
    // sort values listed from index 6 down to 0
    ramp = {6'd5, 6'd60, 6'd50, 6'd40, 6'd30, 6'd20, 6'd10};
    add_row(graded(ramp, '0, '0), 1'b0, '0, 8'hFF, 1'b1);
    // all keys tied so only index 0 wins
    add_row(graded({N_CAND{6'd12}}, '0, '0), 1'b0, '0, 8'hFF, 1'b1);
    // busy 40 at index 3 still blocks lower keys
    g = graded({6'd3, 6'd41, 6'd7, 6'd40, 6'd9, 6'd9, 6'd8}, '0, 7'b0001000);
    add_row(g, 1'b0, '0, 8'hFF, 1'b0);
    g = graded({6'd3, 6'd30, 6'd7, 6'd40, 6'd9, 6'd9, 6'd8}, '0, 7'b0001000);
    add_row(g, 1'b0, '0, 8'hFF, 1'b0);
    add_row(graded(ramp, '0, '0), 1'b0, 7'b0100000, 8'hFF, 1'b0);
    add_row(graded(ramp, '0, '0), 1'b0, 7'h7F, 8'hFF, 1'b0);
    // key edges where the low end wraps to 254
    g = graded(ramp, '0, '0);
    g[0].key  = '0;
    g[0].offs = '0;
    add_row(g, 1'b0, 7'h7E, 8'hFF, 1'b0);
    g = graded({6'd63, {(N_CAND - 1){6'd1}}}, '0, '0);
    g[6].key  = 5'd31;
    g[6].offs = 4'hF;
    add_row(g, 1'b0, '0, 8'hFF, 1'b0);
    // quality order differs from pattern order
    g = graded({6'd60, 6'd50, 6'd40, 6'd30, 6'd20, 6'd10, 6'd5},
               {6'd1, 6'd2, 6'd63, 6'd4, 6'd5, 6'd6, 6'd7}, '0);
    add_row(g, 1'b1, '0, 8'hFF, 1'b0);
    add_row(graded(ramp, {N_CAND{6'd9}}, '0), 1'b1, '0, 8'hFF, 1'b0);
    // output mostly held off so the FIFO fills and in_ready drops
    for (int r = 0; r < 8; r++)
    begin
      for (int i = 0; i < N_CAND; i++)
        g[i] = rand_cand();
      add_row(g, 1'b0, '0, 8'h01, 1'b0);
    end
    // random groups under random back-pressure
    for (int r = 0; r < 24; r++)
    begin
      for (int i = 0; i < N_CAND; i++)
        g[i] = rand_cand();
      a = $random(seed);
      b = $random(seed);
      add_row(g, a[24], a[6:0] & a[13:7] & a[20:14], (b[7:0] & b[15:8]) | 8'h01, 1'b0);
    end
  endtask

  // --------------------
  // checks
  // --------------------

  task automatic check_best(input string name, input best_t exp, input best_t act);
    if (exp !== act)
    begin
      errors++;
      $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      errors++;
      $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_lat(input string name, input int exp, input int act);
    if (exp != act)
    begin
      errors++;
      $display("Fail time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
    end
  endtask

  // --------------------
  // bus tasks
  // --------------------

  // entered and left 1 ns after a rising edge
  task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    waited  = 0;
    @(negedge clk);
    while (!pready && waited < TIMEOUT)
    begin
      waited++;
      @(negedge clk);
    end
    if (!pready)
    begin
      errors++;
      $display("timeout: APB access to %h never saw pready", addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] unused;
    logic        err;
    apb_access(1'b1, addr, data, unused, err);
    check_reg("pslverr", 32'(exp_err), 32'(err));
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data,
                          input logic exp_err);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_reg("pslverr", 32'(exp_err), 32'(err));
  endtask

  task automatic send_group(input grp_t g, input logic lat);
    int waited;
    in_group = g;
    in_valid = 1'b1;
    waited   = 0;
    @(negedge clk);
    while (!in_ready && waited < TIMEOUT)
    begin
      waited++;
      @(negedge clk);
    end
    if (waited > 0)
      saw_in_stall = 1'b1;
    if (!in_ready)
    begin
      errors++;
      $display("timeout: in_ready stayed low, group was never accepted");
    end
    lat_q.push_back(lat ? cyc : -1);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT)
    begin
      waited++;
      @(posedge clk);
      #1;
    end
    if (exp_q.size() != 0)
    begin
      errors++;
      $display("timeout: %0d results never came out", exp_q.size());
    end
  endtask

  // --------------------
  // output side
  // --------------------

  initial
  begin : monitor
    best_t e;
    int    t;
    out_ready = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      out_ready = cur_pat[cyc[2:0]];
      @(negedge clk);
      if (out_valid && out_ready)
      begin
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("out_valid came with no group pending at %0t", $time);
        end
        else
        begin
          e = exp_q.pop_front();
          t = lat_q.pop_front();
          check_best("out_best", e, out_best);
          // result leaves 3 edges after the input transfer
          if (t >= 0)
            check_lat("latency", 3, cyc - t);
          last_exp = e;
          accepted++;
        end
      end
    end
  end

  // --------------------
  // main sequence
  // --------------------

  initial
  begin : main
    stim_t             row;
    logic [31:0]       rdata;
    logic              cur_qlt;
    logic [N_CAND-1:0] cur_mask;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_group = '0;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    cur_qlt  = 1'b0;
    cur_mask = '0;
    build_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_reg("in_ready", 32'd0, 32'(in_ready));
    check_reg("out_valid", 32'd0, 32'(out_valid));
    check_reg("pslverr", 32'd0, 32'(pslverr));
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    // all four registers start at zero
    for (int k = 0; k < 4; k++)
    begin
      apb_read(APB_AW'(4 * k), rdata, 1'b0);
      check_reg("reset value", 32'd0, rdata);
    end
    foreach (table_q[r])
    begin
      row = table_q[r];
      if (row.lat_chk)
        wait_drain();
      if (row.sort_on_qlt != cur_qlt)
      begin
        apb_write(CTRL, 32'(row.sort_on_qlt), 1'b0);
        cur_qlt = row.sort_on_qlt;
      end
      if (row.bsy_mask != cur_mask)
      begin
        apb_write(BSY_MASK, 32'(row.bsy_mask), 1'b0);
        cur_mask = row.bsy_mask;
      end
      cur_pat = row.rdy_pat;
      exp_q.push_back(ref_best(row.grp, row.sort_on_qlt, row.bsy_mask));
      send_group(row.grp, row.lat_chk);
    end
    cur_pat = 8'hFF;
    wait_drain();
    check_reg("results", 32'(table_q.size()), 32'(accepted));
    apb_read(COUNT, rdata, 1'b0);
    check_reg("COUNT", 32'(accepted), rdata);
    apb_read(LAST, rdata, 1'b0);
    check_reg("LAST", 32'({last_exp.bsy, last_exp.qlt, last_exp.subkey}), rdata);
    apb_read(CTRL, rdata, 1'b0);
    check_reg("CTRL", 32'(cur_qlt), rdata);
    apb_read(BSY_MASK, rdata, 1'b0);
    check_reg("BSY_MASK", 32'(cur_mask), rdata);
    // status is read only and 0x10 is not mapped
    apb_write(COUNT, 32'h0000FFFF, 1'b1);
    apb_read(8'h10, rdata, 1'b1);
    apb_read(COUNT, rdata, 1'b0);
    check_reg("COUNT", 32'(accepted), rdata);
    if (!saw_in_stall)
    begin
      errors++;
      $display("in_ready never fell while the FIFO was backed up");
    end
    $display("checks done, errors: %0d", errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* files.f */
logic/sorter_pkg.sv
logic/candidate_sampler.sv
logic/candidate_fifo.sv
logic/best_1of7_sorter.sv
logic/sorter_apb_regs.sv
logic/clct_sorter_top.sv
tb/tb_clct_sorter.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_clct_sorter -f files.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
